/* hdl/rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // stores
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_t;

    // also carries the B format, whose bits sit in the same places
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_t;

    // also carries the J format
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_t;

    typedef union packed {
        r_t r;
        i_t i;
        s_t s;
        u_t u;
    } inst_u;

endpackage

/* hdl/core_pkg.sv */
package core_pkg;

    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] strb_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_t;

endpackage

/* hdl/fetch.sv */
`timescale 1ns/1ps

module fetch #(
    parameter rv32i_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             flush,
    input  rv32i_pkg::word_t new_pc,
    output logic             inst_rden,
    output rv32i_pkg::word_t inst_addr,
    input  rv32i_pkg::word_t inst_rdata,
    output rv32i_pkg::word_t inst_pc,
    output rv32i_pkg::word_t inst_data,
    output logic             inst_valid
);
    import rv32i_pkg::*;

    word_t pc;
    word_t held_data;
    logic  run;
    logic  held;

    // a flush fetches the target in the same cycle
    assign inst_rden = run && (flush || !stall);
    assign inst_addr = flush ? new_pc : pc;
    assign inst_data = held ? held_data : inst_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run        <= 1'b0;
            held       <= 1'b0;
            inst_valid <= 1'b0;
            pc         <= RESET_PC;
        end else begin
            run <= 1'b1;
            if (inst_rden) begin
                pc      <= inst_addr + 32'd4;
                inst_pc <= inst_addr;
            end
            if (flush || !stall) begin
                inst_valid <= inst_rden;
                held       <= 1'b0;
            end else begin
                // decode is frozen, keep the word it has not taken yet
                held      <= 1'b1;
                held_data <= inst_data;
            end
        end
    end

endmodule

/* hdl/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               inst_valid,
    input  rv32i_pkg::word_t   inst_pc,
    input  rv32i_pkg::word_t   inst_data,
    output logic               d_valid,
    output rv32i_pkg::word_t   d_pc,
    output rv32i_pkg::opcode_t d_opcode,
    output core_pkg::reg_idx_t d_rd,
    output core_pkg::reg_idx_t d_rs1,
    output core_pkg::reg_idx_t d_rs2,
    output logic [2:0]         d_funct3,
    output core_pkg::alu_op_t  d_alu_op,
    output rv32i_pkg::word_t   d_imm
);
    import rv32i_pkg::*;
    import core_pkg::*;

    inst_u   inst;
    opcode_t opcode;
    word_t   imm;
    alu_op_t alu_op;
    logic    use_rs1;
    logic    use_rs2;

    assign inst   = inst_data;
    assign opcode = opcode_t'(inst.r.opcode);

    // unused source fields read as x0 so they never cause a stall
    assign use_rs1 = inst_valid && !(opcode inside {LUI, AUIPC, JAL});
    assign use_rs2 = inst_valid && (opcode inside {OP, BRANCH, STORE});

    always_comb begin
        case (opcode)
            STORE:
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            BRANCH:
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_lo[0], inst.s.imm_hi[5:0],
                       inst.s.imm_lo[4:1], 1'b0};
            LUI, AUIPC:
                imm = {inst.u.imm, 12'h000};
            JAL:
                imm = {{12{inst.u.imm[19]}}, inst.u.imm[7:0], inst.u.imm[8],
                       inst.u.imm[18:9], 1'b0};
            default:
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        endcase
    end

    always_comb begin
        alu_op = ADD;
        if (opcode == LUI) begin
            alu_op = PASS_B;
        end else if (opcode == OP || opcode == OP_IMM) begin
            case (inst.r.funct3)
                3'b000: alu_op = (opcode == OP && inst.r.funct7[5]) ? SUB : ADD;
                3'b001: alu_op = SLL;
                3'b010: alu_op = SLT;
                3'b011: alu_op = SLTU;
                3'b100: alu_op = XOR;
                // bit 30 picks the arithmetic shift in both formats
                3'b101: alu_op = inst.r.funct7[5] ? SRA : SRL;
                3'b110: alu_op = OR;
                default: alu_op = AND;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= inst_valid;
        end
        if (!stall) begin
            d_pc     <= inst_pc;
            d_opcode <= opcode;
            d_rd     <= inst.r.rd;
            d_rs1    <= use_rs1 ? inst.r.rs1 : 5'd0;
            d_rs2    <= use_rs2 ? inst.r.rs2 : 5'd0;
            d_funct3 <= inst.r.funct3;
            d_alu_op <= alu_op;
            d_imm    <= imm;
        end
    end

endmodule

/* hdl/rv32i_reg.sv */
`timescale 1ns/1ps

module rv32i_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output rv32i_pkg::word_t   rs1_data,
    output rv32i_pkg::word_t   rs2_data,
    output logic               rs1_valid,
    output logic               rs2_valid,
    input  logic               wb_en,
    input  core_pkg::reg_idx_t wb_rd,
    input  rv32i_pkg::word_t   wb_data,
    input  logic               fwd_exec_en,
    input  core_pkg::reg_idx_t fwd_exec_rd,
    input  rv32i_pkg::word_t   fwd_exec_data,
    input  logic               fwd_load_pending
);
    import rv32i_pkg::*;
    import core_pkg::*;

    word_t regs [1:31];

    // valid bit on top, then the value
    function automatic logic [32:0] read_port(input reg_idx_t idx);
        logic [32:0] r;
        if (idx == 5'd0) begin
            r = {1'b1, 32'h0};
        end else if (fwd_load_pending && idx == fwd_exec_rd) begin
            r = {1'b0, 32'h0};
        end else if (fwd_exec_en && idx == fwd_exec_rd) begin
            r = {1'b1, fwd_exec_data};
        end else if (wb_en && idx == wb_rd) begin
            r = {1'b1, wb_data};
        end else begin
            r = {1'b1, regs[idx]};
        end
        return r;
    endfunction

    always_comb begin
        {rs1_valid, rs1_data} = read_port(rs1);
        {rs2_valid, rs2_data} = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst_n && wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

/* hdl/exec.sv */
`timescale 1ns/1ps

module exec (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               bubble,
    input  logic               d_valid,
    input  rv32i_pkg::word_t   d_pc,
    input  rv32i_pkg::opcode_t d_opcode,
    input  core_pkg::reg_idx_t d_rd,
    input  logic [2:0]         d_funct3,
    input  core_pkg::alu_op_t  d_alu_op,
    input  rv32i_pkg::word_t   d_imm,
    input  rv32i_pkg::word_t   rs1_data,
    input  rv32i_pkg::word_t   rs2_data,
    output logic               e_reg_w,
    output core_pkg::reg_idx_t e_rd,
    output rv32i_pkg::word_t   e_result,
    output logic               e_mem_r,
    output logic               e_mem_w,
    output logic [2:0]         e_funct3,
    output rv32i_pkg::word_t   e_addr,
    output rv32i_pkg::word_t   e_store_data,
    output logic               e_jmp_do,
    output rv32i_pkg::word_t   e_jmp_pc
);
    import rv32i_pkg::*;
    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t addr;
    word_t result;
    word_t jmp_pc;
    logic  taken;
    logic  live;
    logic  is_jump;

    assign live    = d_valid && !bubble && !flush;
    assign is_jump = d_opcode == JAL || d_opcode == JALR;

    // auipc adds to the pc, lui passes the immediate
    assign op_a = (d_opcode == AUIPC) ? d_pc : rs1_data;
    assign op_b = (d_opcode == OP) ? rs2_data : d_imm;
    assign addr = rs1_data + d_imm;

    always_comb begin
        case (d_alu_op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            SLL:     alu_out = op_a << op_b[4:0];
            SLT:     alu_out = {31'h0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_out = {31'h0, op_a < op_b};
            XOR:     alu_out = op_a ^ op_b;
            SRL:     alu_out = op_a >> op_b[4:0];
            SRA:     alu_out = $signed(op_a) >>> op_b[4:0];
            OR:      alu_out = op_a | op_b;
            AND:     alu_out = op_a & op_b;
            default: alu_out = op_b;
        endcase
    end

    always_comb begin
        case (d_funct3)
            F3_BEQ:  taken = rs1_data == rs2_data;
            F3_BNE:  taken = rs1_data != rs2_data;
            F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
            F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            F3_BLTU: taken = rs1_data < rs2_data;
            F3_BGEU: taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    // jumps write the link value
    assign result = is_jump ? d_pc + 32'd4 : alu_out;
    assign jmp_pc = (d_opcode == JALR) ? {addr[31:1], 1'b0} : d_pc + d_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_reg_w  <= 1'b0;
            e_mem_r  <= 1'b0;
            e_mem_w  <= 1'b0;
            e_jmp_do <= 1'b0;
        end else begin
            e_reg_w  <= live && (d_opcode inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR});
            e_mem_r  <= live && d_opcode == LOAD;
            e_mem_w  <= live && d_opcode == STORE;
            e_jmp_do <= live && (is_jump || (d_opcode == BRANCH && taken));
        end
        e_rd         <= d_rd;
        e_result     <= result;
        e_funct3     <= d_funct3;
        e_addr       <= addr;
        e_store_data <= rs2_data;
        e_jmp_pc     <= jmp_pc;
    end

endmodule

/* hdl/mread.sv */
`timescale 1ns/1ps

module mread (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               e_reg_w,
    input  core_pkg::reg_idx_t e_rd,
    input  rv32i_pkg::word_t   e_result,
    input  logic               e_mem_r,
    input  logic               e_mem_w,
    input  logic [2:0]         e_funct3,
    input  rv32i_pkg::word_t   e_addr,
    input  rv32i_pkg::word_t   e_store_data,
    input  logic               e_jmp_do,
    input  rv32i_pkg::word_t   e_jmp_pc,
    output logic               data_rden,
    output rv32i_pkg::word_t   data_raddr,
    input  rv32i_pkg::word_t   data_rdata,
    output logic               wb_en,
    output core_pkg::reg_idx_t wb_rd,
    output rv32i_pkg::word_t   wb_data,
    output logic               m_mem_w,
    output logic [2:0]         m_funct3,
    output rv32i_pkg::word_t   m_addr,
    output rv32i_pkg::word_t   m_store_data,
    output logic               m_jmp_do,
    output rv32i_pkg::word_t   m_jmp_pc
);
    import rv32i_pkg::*;

    logic  wb_load;
    word_t wb_result;
    word_t lane;
    word_t load_data;

    assign data_rden  = e_mem_r && !flush;
    assign data_raddr = {e_addr[31:2], 2'b00};

    // addressed byte or halfword moved down to bit 0
    assign lane = data_rdata >> {m_addr[1:0], 3'b000};

    always_comb begin
        case (m_funct3)
            F3_LB:   load_data = {{24{lane[7]}}, lane[7:0]};
            F3_LBU:  load_data = {24'h0, lane[7:0]};
            F3_LH:   load_data = {{16{lane[15]}}, lane[15:0]};
            F3_LHU:  load_data = {16'h0, lane[15:0]};
            default: load_data = lane;
        endcase
    end

    assign wb_data = wb_load ? load_data : wb_result;

    always_ff @(posedge clk) begin
        // the entry behind a taken jump is dropped here
        if (!rst_n || flush) begin
            wb_en    <= 1'b0;
            m_mem_w  <= 1'b0;
            m_jmp_do <= 1'b0;
        end else begin
            wb_en    <= e_reg_w || e_mem_r;
            m_mem_w  <= e_mem_w;
            m_jmp_do <= e_jmp_do;
        end
        wb_rd        <= e_rd;
        wb_load      <= e_mem_r;
        wb_result    <= e_result;
        m_funct3     <= e_funct3;
        m_addr       <= e_addr;
        m_store_data <= e_store_data;
        m_jmp_pc     <= e_jmp_pc;
    end

endmodule

/* hdl/mwrite.sv */
`timescale 1ns/1ps

module mwrite (
    input  logic             m_mem_w,
    input  logic [2:0]       m_funct3,
    input  rv32i_pkg::word_t m_addr,
    input  rv32i_pkg::word_t m_store_data,
    output logic             data_wren,
    output rv32i_pkg::word_t data_waddr,
    output core_pkg::strb_t  data_wstrb,
    output rv32i_pkg::word_t data_wdata
);
    import rv32i_pkg::*;

    assign data_wren  = m_mem_w;
    assign data_waddr = {m_addr[31:2], 2'b00};

    // data goes to every lane, the strobe picks the live ones
    always_comb begin
        case (m_funct3)
            F3_SB: begin
                data_wdata = {4{m_store_data[7:0]}};
                data_wstrb = 4'b0001 << m_addr[1:0];
            end
            F3_SH: begin
                data_wdata = {2{m_store_data[15:0]}};
                data_wstrb = m_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data_wdata = m_store_data;
                data_wstrb = 4'b1111;
            end
        endcase
    end

endmodule

/* hdl/core.sv */
`timescale 1ns/1ps

module core #(
    parameter rv32i_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    output logic             inst_rden,
    output rv32i_pkg::word_t inst_addr,
    input  rv32i_pkg::word_t inst_rdata,
    output logic             data_rden,
    output rv32i_pkg::word_t data_raddr,
    input  rv32i_pkg::word_t data_rdata,
    output logic             data_wren,
    output rv32i_pkg::word_t data_waddr,
    output core_pkg::strb_t  data_wstrb,
    output rv32i_pkg::word_t data_wdata
);
    import rv32i_pkg::*;
    import core_pkg::*;

    logic     stall;
    logic     flush;

    // fetch to decode
    word_t    inst_pc;
    word_t    inst_data;
    logic     inst_valid;

    // decode to register access and exec
    logic     d_valid;
    word_t    d_pc;
    opcode_t  d_opcode;
    reg_idx_t d_rd;
    reg_idx_t d_rs1;
    reg_idx_t d_rs2;
    logic [2:0] d_funct3;
    alu_op_t  d_alu_op;
    word_t    d_imm;

    word_t    rs1_data;
    word_t    rs2_data;
    logic     rs1_valid;
    logic     rs2_valid;

    // exec output register
    logic     e_reg_w;
    reg_idx_t e_rd;
    word_t    e_result;
    logic     e_mem_r;
    logic     e_mem_w;
    logic [2:0] e_funct3;
    word_t    e_addr;
    word_t    e_store_data;
    logic     e_jmp_do;
    word_t    e_jmp_pc;

    // memory read stage
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     m_mem_w;
    logic [2:0] m_funct3;
    word_t    m_addr;
    word_t    m_store_data;
    logic     m_jmp_do;
    word_t    m_jmp_pc;

    // load-use hazard holds fetch and decode for a cycle
    assign stall = !(rs1_valid && rs2_valid);
    assign flush = m_jmp_do;

    fetch #(
        .RESET_PC(RESET_PC)
    ) fetch_inst (
        .clk, .rst_n, .stall, .flush,
        .new_pc(m_jmp_pc),
        .inst_rden, .inst_addr, .inst_rdata,
        .inst_pc, .inst_data, .inst_valid
    );

    decode decode_inst (
        .clk, .rst_n, .stall, .flush,
        .inst_valid, .inst_pc, .inst_data,
        .d_valid, .d_pc, .d_opcode, .d_rd, .d_rs1, .d_rs2,
        .d_funct3, .d_alu_op, .d_imm
    );

    rv32i_reg rv32i_reg_inst (
        .clk, .rst_n,
        .rs1(d_rs1),
        .rs2(d_rs2),
        .rs1_data, .rs2_data, .rs1_valid, .rs2_valid,
        .wb_en, .wb_rd, .wb_data,
        .fwd_exec_en(e_reg_w),
        .fwd_exec_rd(e_rd),
        .fwd_exec_data(e_result),
        .fwd_load_pending(e_mem_r)
    );

    exec exec_inst (
        .clk, .rst_n, .flush,
        .bubble(stall),
        .d_valid, .d_pc, .d_opcode, .d_rd, .d_funct3, .d_alu_op, .d_imm,
        .rs1_data, .rs2_data,
        .e_reg_w, .e_rd, .e_result, .e_mem_r, .e_mem_w, .e_funct3,
        .e_addr, .e_store_data, .e_jmp_do, .e_jmp_pc
    );

    mread mread_inst (
        .clk, .rst_n, .flush,
        .e_reg_w, .e_rd, .e_result, .e_mem_r, .e_mem_w, .e_funct3,
        .e_addr, .e_store_data, .e_jmp_do, .e_jmp_pc,
        .data_rden, .data_raddr, .data_rdata,
        .wb_en, .wb_rd, .wb_data,
        .m_mem_w, .m_funct3, .m_addr, .m_store_data, .m_jmp_do, .m_jmp_pc
    );

    mwrite mwrite_inst (
        .m_mem_w, .m_funct3, .m_addr, .m_store_data,
        .data_wren, .data_waddr, .data_wstrb, .data_wdata
    );

endmodule

/* test/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
    import rv32i_pkg::*;
    import core_pkg::*;

    localparam word_t JAL_SELF = 32'h0000_006f;
    localparam word_t DUMP_BASE = 32'h0000_0400;
    localparam word_t SLOT_ADDR = 32'h0000_07f0;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  inst_rden;
    word_t inst_addr;
    word_t inst_rdata;
    logic  data_rden;
    word_t data_raddr;
    word_t data_rdata;
    logic  data_wren;
    word_t data_waddr;
    strb_t data_wstrb;
    word_t data_wdata;

    word_t rom [0:1023];
    word_t ram [0:1023];
    word_t ref_ram [0:1023];
    word_t inst_next;
    word_t rdata_next;

    word_t exp_addr [$];
    word_t exp_data [$];
    strb_t exp_strb [$];

    logic [31:0] lfsr;
    int pc_w;
    int seen;
    int limit;
    int cycles;
    int n_exec;

    core #(
        .RESET_PC(32'h0000_0000)
    ) core_inst (
        .clk, .rst_n,
        .inst_rden, .inst_addr, .inst_rdata,
        .data_rden, .data_raddr, .data_rdata,
        .data_wren, .data_waddr, .data_wstrb, .data_wdata
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (exp !== got) begin
            $display("Mismatch %s expected %h got %h", name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_strb(input string name, input strb_t exp, input strb_t got);
        if (exp !== got) begin
            $display("Mismatch %s expected %h got %h", name, exp, got);
            stop_with_failure();
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    // x30 is kept for the jalr base
    function automatic reg_idx_t rnd_reg();
        logic [31:0] r;
        r = rand_bits(5);
        return reg_idx_t'(1 + r % 29);
    endfunction

    function automatic word_t lane_mask(input strb_t s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    task automatic emit(input word_t w);
        rom[pc_w] = w;
        pc_w++;
    endtask

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // three stores that a taken jump must squash
    task automatic emit_slots();
        for (int k = 0; k < 3; k++) begin
            emit(enc_s(SLOT_ADDR[11:0], rnd_reg(), 5'd0, F3_SW));
        end
    endtask

    task automatic gen_alu();
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t last;
        logic [2:0] f3;
        logic [31:0] kind;
        logic [31:0] imm;
        logic [6:0] f7;
        last = rnd_reg();
        repeat (12) begin
            kind = rand_bits(2);
            rd = rnd_reg();
            rs1 = rand_bits(1) ? last : rnd_reg();
            f3 = 3'(rand_bits(3));
            imm = rand_bits(20);
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1)) ? 7'h20 : 7'h00;
            case (kind[1:0])
                2'd0: emit({f7, last, rs1, f3, rd, OP});
                2'd1: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm[11:5] = (f3 == 3'b101) ? f7 : 7'h00;
                    end
                    emit(enc_i(imm[11:0], rs1, f3, rd, OP_IMM));
                end
                2'd2: emit({imm[19:0], rd, LUI});
                default: emit({imm[19:0], rd, AUIPC});
            endcase
            last = rd;
        end
    endtask

    task automatic gen_loads();
        logic [2:0] f3s [5];
        reg_idx_t a;
        reg_idx_t b;
        logic [31:0] w;
        f3s = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
        foreach (f3s[k]) begin
            for (int off = 0; off < 4; off++) begin
                if ((f3s[k][1] && off != 0) || (f3s[k][0] && off[0])) begin
                    continue;
                end
                a = rnd_reg();
                b = rnd_reg();
                w = rand_bits(8);
                emit(enc_i({2'b00, w[7:0], 2'(off)}, 5'd0, f3s[k], a, LOAD));
                // user right behind the load
                emit({7'h00, a, a, 3'b000, b, OP});
            end
        end
    endtask

    task automatic gen_stores();
        logic [2:0] f3s [3];
        logic [31:0] w;
        f3s = '{F3_SB, F3_SH, F3_SW};
        foreach (f3s[k]) begin
            for (int off = 0; off < 4; off++) begin
                if ((f3s[k][1] && off != 0) || (f3s[k][0] && off[0])) begin
                    continue;
                end
                w = rand_bits(8);
                emit(enc_s({2'b00, w[7:0], 2'(off)}, rnd_reg(), 5'd0, f3s[k]));
                emit(enc_i({2'b00, w[7:0], 2'b00}, 5'd0, F3_LW, rnd_reg(), LOAD));
            end
        end
    endtask

    task automatic gen_jumps();
        logic [2:0] f3s [6];
        reg_idx_t a;
        f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        foreach (f3s[k]) begin
            a = rnd_reg();
            emit(enc_b(13'd16, rand_bits(1) ? a : rnd_reg(), a, f3s[k]));
            emit_slots();
        end
        emit(enc_j(21'd16, rnd_reg()));
        emit_slots();
        emit({20'h0, 5'd30, AUIPC});
        emit(enc_i(12'd20, 5'd30, 3'b000, rnd_reg(), JALR));
        emit_slots();
    endtask

    task automatic gen_program();
        logic [31:0] v;
        pc_w = 0;
        for (int r = 1; r < 32; r++) begin
            v = rand_bits(32);
            emit({v[31:12], 5'(r), LUI});
            emit(enc_i(v[11:0], 5'(r), 3'b000, 5'(r), OP_IMM));
        end
        repeat (6) begin
            gen_alu();
            gen_loads();
            gen_stores();
            gen_jumps();
            for (int r = 1; r < 32; r++) begin
                emit(enc_s(12'(DUMP_BASE + 4 * r), 5'(r), 5'd0, F3_SW));
            end
        end
        emit(JAL_SELF);
    endtask

    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // reference ISS over the same ROM that records stores in program order
    function automatic int iss_run();
        word_t x [32];
        word_t pc;
        word_t nxt;
        word_t w;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        word_t iimm;
        word_t d;
        inst_u u;
        logic [2:0] f3;
        logic wr;
        strb_t st;
        int n;
        foreach (x[k]) begin
            x[k] = 32'h0;
        end
        pc = 32'h0;
        n = 0;
        while (n < 20000) begin
            w = rom[pc[11:2]];
            if (w == JAL_SELF) begin
                break;
            end
            u = w;
            f3 = u.r.funct3;
            a = x[u.r.rs1];
            b = x[u.r.rs2];
            iimm = {{20{u.i.imm[11]}}, u.i.imm};
            nxt = pc + 32'd4;
            wr = 1'b1;
            res = 32'h0;
            n++;
            case (u.r.opcode)
                OP:     res = ref_alu(f3, u.r.funct7[5], a, b);
                OP_IMM: res = ref_alu(f3, f3 == 3'b101 && u.i.imm[10], a, iimm);
                LUI:    res = {u.u.imm, 12'h000};
                AUIPC:  res = pc + {u.u.imm, 12'h000};
                JAL: begin
                    res = pc + 32'd4;
                    nxt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                JALR: begin
                    res = pc + 32'd4;
                    nxt = (a + iimm) & ~32'd1;
                end
                BRANCH: begin
                    wr = 1'b0;
                    if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b) ||
                        (f3 == F3_BLT && $signed(a) < $signed(b)) ||
                        (f3 == F3_BGE && $signed(a) >= $signed(b)) ||
                        (f3 == F3_BLTU && a < b) || (f3 == F3_BGEU && a >= b)) begin
                        nxt = pc + {{20{u.s.imm_hi[6]}}, u.s.imm_lo[0], u.s.imm_hi[5:0],
                                    u.s.imm_lo[4:1], 1'b0};
                    end
                end
                LOAD: begin
                    addr = a + iimm;
                    d = ref_ram[addr[11:2]] >> (8 * addr[1:0]);
                    case (f3)
                        F3_LB:   res = {{24{d[7]}}, d[7:0]};
                        F3_LBU:  res = {24'h0, d[7:0]};
                        F3_LH:   res = {{16{d[15]}}, d[15:0]};
                        F3_LHU:  res = {16'h0, d[15:0]};
                        default: res = d;
                    endcase
                end
                default: begin
                    wr = 1'b0;
                    addr = a + {{20{u.s.imm_hi[6]}}, u.s.imm_hi, u.s.imm_lo};
                    d = b << (8 * addr[1:0]);
                    st = (f3 == F3_SB) ? 4'b0001 : (f3 == F3_SH) ? 4'b0011 : 4'b1111;
                    st = st << addr[1:0];
                    ref_ram[addr[11:2]] = (ref_ram[addr[11:2]] & ~lane_mask(st)) |
                                          (d & lane_mask(st));
                    exp_addr.push_back({addr[31:2], 2'b00});
                    exp_data.push_back(d);
                    exp_strb.push_back(st);
                end
            endcase
            if (wr && u.r.rd != 5'd0) begin
                x[u.r.rd] = res;
            end
            pc = nxt;
        end
        return n;
    endfunction

    // memories sample at the falling edge and write before they read
    always @(negedge clk) begin
        word_t m;
        if (rst_n) begin
            if (data_wren) begin
                if (seen >= exp_addr.size()) begin
                    $display("unexpected store to %h after all expected stores", data_waddr);
                    stop_with_failure();
                end
                m = lane_mask(exp_strb[seen]);
                check_word("data_waddr", exp_addr[seen], data_waddr);
                check_strb("data_wstrb", exp_strb[seen], data_wstrb);
                check_word("data_wdata", exp_data[seen] & m, data_wdata & m);
                seen++;
                ram[data_waddr[11:2]] = (ram[data_waddr[11:2]] & ~lane_mask(data_wstrb)) |
                                        (data_wdata & lane_mask(data_wstrb));
            end
            if (data_rden) begin
                rdata_next = ram[data_raddr[11:2]];
            end
            if (inst_rden) begin
                inst_next = rom[inst_addr[11:2]];
            end
        end
    end

    always @(posedge clk) begin
        #1;
        inst_rdata = inst_next;
        data_rdata = rdata_next;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: expected stores not all seen");
                stop_with_failure();
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        inst_rdata = 32'h0;
        data_rdata = 32'h0;
        inst_next = 32'h0;
        rdata_next = 32'h0;
        lfsr = 32'h675a;
        seen = 0;
        cycles = 0;
        for (int k = 0; k < 1024; k++) begin
            rom[k] = JAL_SELF;
            ram[k] = (32'(k) * 32'h9e37_79b1) ^ {22'h2d_5a5a, 10'(k)};
            ref_ram[k] = ram[k];
        end
        gen_program();
        n_exec = iss_run();
        limit = 8 * n_exec + 200;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        while (seen < exp_addr.size()) begin
            @(posedge clk);
        end
        // idle a little so a stray store would still be caught
        repeat (10) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* list.f */
hdl/rv32i_pkg.sv
hdl/core_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/rv32i_reg.sv
hdl/exec.sv
hdl/mread.sv
hdl/mwrite.sv
hdl/core.sv
test/core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module core_tb -Mdir obj_dir || exit 1
out=$(./obj_dir/Vcore_tb) ; echo "$out"
echo "$out" | grep -qx "Testbench passed" && exit 0 || exit 1
